// File: hdl/rotshift_pkg.sv
// shift unit package with widths, opcode and mask encodings and pipeline structs.
`default_nettype none

package rotshift_pkg;

   localparam int DATA_W = 64;
   localparam int AMT_W  = 6;

   // codes 5 to 7 are not assigned and come back illegal.
   typedef enum logic [2:0] {
      OP_ROL = 3'd0,
      OP_ROR = 3'd1,
      OP_SLL = 3'd2,
      OP_SRL = 3'd3,
      OP_SRA = 3'd4
   } shift_op_e;

   typedef enum logic [1:0] {
      MASK_NONE = 2'd0,
      MASK_LOW  = 2'd1,
      MASK_HIGH = 2'd2
   } mask_kind_e;

   typedef struct packed {
      shift_op_e          op;
      logic [DATA_W-1:0]  operand;
      logic [AMT_W-1:0]   amount;
   } shift_req_t;

   typedef struct packed {
      logic [DATA_W-1:0]  operand;
      logic [AMT_W-1:0]   rot_amt;
      logic [AMT_W-1:0]   shift_amt;
      mask_kind_e         mask_kind;
      logic               fill;
      logic               illegal;
   } shift_ctrl_t;

   typedef struct packed {
      logic [DATA_W-1:0]  rotated;
      logic [DATA_W-1:0]  mask;
      logic               fill;
      logic               illegal;
   } exec_t;

   typedef struct packed {
      logic [DATA_W-1:0]  data;
      logic               illegal;
   } shift_rsp_t;

endpackage

`default_nettype wire

// File: hdl/shift_decode.sv
// decode stage, maps an opcode onto a left-rotate amount, a mask kind and a fill bit.
`default_nettype none

module shift_decode (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  rotshift_pkg::shift_req_t  in,
   output logic                      out_valid,
   input  logic                      out_ready,
   output rotshift_pkg::shift_ctrl_t out
);

   rotshift_pkg::shift_ctrl_t ctrl_next;
   logic                      accept;

   // one slot; it frees up in the same cycle the consumer takes it.
   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   always_comb
   begin
      ctrl_next.operand   = in.operand;
      ctrl_next.shift_amt = in.amount;
      ctrl_next.rot_amt   = in.amount;
      ctrl_next.mask_kind = rotshift_pkg::MASK_NONE;
      ctrl_next.fill      = 1'b0;
      ctrl_next.illegal   = 1'b0;
      case (in.op)
         rotshift_pkg::OP_ROL:
         begin
            ctrl_next.rot_amt = in.amount;
         end
         rotshift_pkg::OP_ROR:
         begin
            // rotate right by n is rotate left by 64 - n.
            ctrl_next.rot_amt = -in.amount;
         end
         rotshift_pkg::OP_SLL:
         begin
            ctrl_next.mask_kind = rotshift_pkg::MASK_LOW;
         end
         rotshift_pkg::OP_SRL:
         begin
            ctrl_next.rot_amt   = -in.amount;
            ctrl_next.mask_kind = rotshift_pkg::MASK_HIGH;
         end
         rotshift_pkg::OP_SRA:
         begin
            ctrl_next.rot_amt   = -in.amount;
            ctrl_next.mask_kind = rotshift_pkg::MASK_HIGH;
            ctrl_next.fill      = in.operand[rotshift_pkg::DATA_W-1];
         end
         default:
         begin
            ctrl_next.rot_amt = '0;
            ctrl_next.illegal = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
      end
      else if (accept)
      begin
         out_valid <= 1'b1;
      end
      else if (out_ready)
      begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         out <= ctrl_next;
      end
   end

endmodule

`default_nettype wire

// File: hdl/barrel_rotator.sv
// execute stage, a registered logarithmic left rotator with a thermometer mask beside it.
`default_nettype none

module barrel_rotator (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  rotshift_pkg::shift_ctrl_t in,
   output logic                      out_valid,
   input  logic                      out_ready,
   output rotshift_pkg::exec_t       out
);

   localparam int W = rotshift_pkg::DATA_W;
   localparam int S = rotshift_pkg::AMT_W;

   // stage[0] is the operand, stage[S] the fully rotated word.
   logic [S:0][W-1:0]   stage;
   logic [W-1:0]        low_mask;
   logic [W-1:0]        high_mask;
   rotshift_pkg::exec_t exec_next;
   logic                accept;

   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   assign stage[0] = in.operand;

   // each level rotates by 2**k when bit k of the amount is set.
   for (genvar k = 0; k < S; k++)
   begin : g_level
      localparam int SH = 1 << k;

      logic [W-1:0] rotated;

      assign rotated = {stage[k][W-1-SH:0], stage[k][W-1:W-SH]};
      assign stage[k+1] = in.rot_amt[k] ? rotated : stage[k];
   end

   // thermometer codes of shift_amt ones.
   assign low_mask  = ~({W{1'b1}} << in.shift_amt);
   assign high_mask = ~({W{1'b1}} >> in.shift_amt);

   always_comb
   begin
      exec_next.rotated = stage[S];
      exec_next.fill    = in.fill;
      exec_next.illegal = in.illegal;
      case (in.mask_kind)
         rotshift_pkg::MASK_LOW:
         begin
            exec_next.mask = low_mask;
         end
         rotshift_pkg::MASK_HIGH:
         begin
            exec_next.mask = high_mask;
         end
         default:
         begin
            exec_next.mask = '0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
      end
      else if (accept)
      begin
         out_valid <= 1'b1;
      end
      else if (out_ready)
      begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         out <= exec_next;
      end
   end

endmodule

`default_nettype wire

// File: hdl/shift_result.sv
// result stage, merges the rotated word with the fill bit and holds the response.
`default_nettype none

module shift_result (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  rotshift_pkg::exec_t      in,
   output logic                     out_valid,
   input  logic                     out_ready,
   output rotshift_pkg::shift_rsp_t out
);

   localparam int W = rotshift_pkg::DATA_W;

   logic [W-1:0]             fill_word;
   logic [W-1:0]             kept;
   logic [W-1:0]             merged;
   rotshift_pkg::shift_rsp_t rsp_next;
   logic                     accept;

   // a stalled response keeps the register full, which holds off the stage above.
   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   assign fill_word = {W{in.fill}};

   // rotated bits survive where the mask is clear.
   assign kept   = in.rotated & ~in.mask;
   assign merged = kept | (fill_word & in.mask);

   always_comb
   begin
      rsp_next.illegal = in.illegal;
      if (in.illegal)
      begin
         rsp_next.data = '0;
      end
      else
      begin
         rsp_next.data = merged;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
      end
      else if (accept)
      begin
         out_valid <= 1'b1;
      end
      else if (out_ready)
      begin
         out_valid <= 1'b0;
      end
   end

   // loads only on accept, so the response is stable while refused.
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         out <= rsp_next;
      end
   end

endmodule

`default_nettype wire

// File: hdl/rotshift_top.sv
// 64-bit shift and rotate unit, three pipeline stages with valid/ready links.
`default_nettype none

module rotshift_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     req_valid,
   output logic                     req_ready,
   input  rotshift_pkg::shift_req_t req,
   output logic                     rsp_valid,
   input  logic                     rsp_ready,
   output rotshift_pkg::shift_rsp_t rsp
);

   // decode to execute.
   logic                      ctrl_valid;
   logic                      ctrl_ready;
   rotshift_pkg::shift_ctrl_t ctrl;

   // execute to result.
   logic                      exec_valid;
   logic                      exec_ready;
   rotshift_pkg::exec_t       exec;

   shift_decode i_shift_decode (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (req_valid),
      .in_ready  (req_ready),
      .in        (req),
      .out_valid (ctrl_valid),
      .out_ready (ctrl_ready),
      .out       (ctrl)
   );

   barrel_rotator i_barrel_rotator (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (ctrl_valid),
      .in_ready  (ctrl_ready),
      .in        (ctrl),
      .out_valid (exec_valid),
      .out_ready (exec_ready),
      .out       (exec)
   );

   shift_result i_shift_result (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (exec_valid),
      .in_ready  (exec_ready),
      .in        (exec),
      .out_valid (rsp_valid),
      .out_ready (rsp_ready),
      .out       (rsp)
   );

endmodule

`default_nettype wire

// File: bench/rotshift_checker.sv
// testbench checker that follows both handshakes and compares every response with a reference.
`default_nettype none

module rotshift_checker (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     req_valid,
   input  logic                     req_ready,
   input  rotshift_pkg::shift_req_t req,
   input  logic                     rsp_valid,
   input  logic                     rsp_ready,
   input  rotshift_pkg::shift_rsp_t rsp,
   output int                       pending,
   output int                       errors
);
   timeunit 1ns;
   timeprecision 100ps;

   rotshift_pkg::shift_req_t req_q[$];
   int                       accept_cycle[$];
   rotshift_pkg::shift_rsp_t held;
   logic                     holding;
   logic                     head_seen;
   logic                     after_reset;
   logic                     rol_seen;
   logic [63:0]              rol_operand;
   logic [63:0]              rol_data;
   logic [5:0]               rol_amount;
   int                       cycle;
   int                       last_stall;
   int                       rsp_count;
   int                       reported_rsps;
   int                       reported_errors;

   function automatic logic [63:0] rotate_left(input logic [63:0] x, input int n);
      logic [63:0] r;
      for (int i = 0; i < 64; i++)
         r[(i + n) % 64] = x[i];
      return r;
   endfunction

   function automatic logic [63:0] rotate_right(input logic [63:0] x, input int n);
      logic [63:0] r;
      for (int i = 0; i < 64; i++)
         r[i] = x[(i + n) % 64];
      return r;
   endfunction

   // right shifts fill the vacated top bits with zero or with the sign.
   function automatic rotshift_pkg::shift_rsp_t expected_rsp(input rotshift_pkg::shift_req_t r);
      rotshift_pkg::shift_rsp_t e;
      int                       n;
      n         = int'(r.amount);
      e.data    = '0;
      e.illegal = 1'b0;
      case (r.op)
         rotshift_pkg::OP_ROL: e.data = rotate_left(r.operand, n);
         rotshift_pkg::OP_ROR: e.data = rotate_right(r.operand, n);
         rotshift_pkg::OP_SLL: e.data = r.operand << n;
         rotshift_pkg::OP_SRL: e.data = r.operand >> n;
         rotshift_pkg::OP_SRA: e.data = $signed(r.operand) >>> n;
         default: e.illegal = 1'b1;
      endcase
      return e;
   endfunction

   task automatic log_error(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic compare(input rotshift_pkg::shift_req_t r, input rotshift_pkg::shift_rsp_t got);
      rotshift_pkg::shift_rsp_t want;
      logic                     undoes_rol;
      want       = expected_rsp(r);
      undoes_rol = rol_seen && r.op == rotshift_pkg::OP_ROR && r.amount === rol_amount
                   && r.operand === rol_data;
      if (got.data !== want.data)
         log_error($sformatf("Error: rsp.data expected %h, actual %h (op %0d, amount %0d)",
                             want.data, got.data, r.op, r.amount));
      if (got.illegal !== want.illegal)
         log_error($sformatf("Error: rsp.illegal expected %h, actual %h (op %0d)",
                             want.illegal, got.illegal, r.op));
      // a right rotate of the previous left-rotate result must give its operand back.
      if (undoes_rol && got.data !== rol_operand)
         log_error($sformatf("Error: rsp.data rotated back expected %h, actual %h",
                             rol_operand, got.data));
      rol_seen    = (r.op == rotshift_pkg::OP_ROL);
      rol_operand = r.operand;
      rol_amount  = r.amount;
      rol_data    = got.data;
   endtask

   task automatic report(input string name);
      $display("test %s: %0d responses, %0d errors", name, rsp_count - reported_rsps,
               errors - reported_errors);
      reported_rsps   = rsp_count;
      reported_errors = errors;
   endtask

   always @(posedge clk)
   begin
      rotshift_pkg::shift_req_t head;
      if (rst)
      begin
         req_q.delete();
         accept_cycle.delete();
         cycle       = 0;
         last_stall  = 0;
         holding     = 1'b0;
         head_seen   = 1'b0;
         after_reset = 1'b1;
         rol_seen    = 1'b0;
      end
      else
      begin
         cycle++;
         if (after_reset && (rsp_valid !== 1'b0 || req_ready !== 1'b1))
            log_error("outputs were not idle on the first cycle after reset");
         after_reset = 1'b0;
         if (!rsp_ready)
            last_stall = cycle;
         if (holding && (!rsp_valid || rsp !== held))
            log_error("response changed or was withdrawn while it was stalled");
         if (!req_ready && !(rsp_valid && !rsp_ready))
            log_error("req_ready was low while the response port was not stalled");
         // latency only counts when the consumer has not stalled since the request.
         if (rsp_valid && !head_seen && req_q.size() > 0)
         begin
            head_seen = 1'b1;
            if (last_stall <= accept_cycle[0] && cycle - accept_cycle[0] != 3)
               log_error($sformatf("response came %0d cycles after its request instead of 3",
                                   cycle - accept_cycle[0]));
         end
         if (rsp_valid && rsp_ready)
         begin
            rsp_count++;
            head_seen = 1'b0;
            if (req_q.size() == 0)
               log_error("response arrived with no request outstanding");
            else
            begin
               head = req_q.pop_front();
               void'(accept_cycle.pop_front());
               compare(head, rsp);
            end
         end
         holding = rsp_valid && !rsp_ready;
         held    = rsp;
         if (req_valid && req_ready)
         begin
            req_q.push_back(req);
            accept_cycle.push_back(cycle);
         end
      end
      pending = req_q.size();
   end

endmodule

`default_nettype wire

// File: bench/rotshift_tb.sv
// testbench top for the shift and rotate unit that runs each test and prints the outcome.
`default_nettype none

module rotshift_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // requests over all tests.
   localparam int N_REQ = 649;

   logic                     clk;
   logic                     rst;
   logic                     req_valid;
   logic                     req_ready;
   rotshift_pkg::shift_req_t req;
   logic                     rsp_valid;
   logic                     rsp_ready;
   rotshift_pkg::shift_rsp_t rsp;
   int                       pending;
   int                       errors;
   int                       tests;
   logic [31:0]              lfsr_state;
   logic                     stall_mode;
   logic [63:0]              ready_pattern;

   rotshift_top i_rotshift_top (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp)
   );

   rotshift_checker i_checker (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp),
      .pending   (pending),
      .errors    (errors)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // taps 32, 22, 2 and 1.
   function automatic logic lfsr_bit();
      logic fb;
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[62:0], lfsr_bit()};
      return v;
   endfunction

   task automatic send(input logic [2:0] code, input logic [63:0] operand,
                       input logic [5:0] amount);
      @(negedge clk);
      req_valid   = 1'b1;
      req.op      = rotshift_pkg::shift_op_e'(code);
      req.operand = operand;
      req.amount  = amount;
      @(posedge clk);
      while (!req_ready)
         @(posedge clk);
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   task automatic finish_test(input string name);
      idle_cycles(1);
      while (pending != 0)
         @(negedge clk);
      i_checker.report(name);
      tests++;
   endtask

   // the right rotate gets the left-rotated word, so it must return x.
   task automatic rotates_all_amounts();
      logic [63:0] x;
      logic [63:0] y;
      for (int n = 0; n < 64; n++)
      begin
         x = rand_bits(64);
         y = (x << n) | (x >> (64 - n));
         send(rotshift_pkg::OP_ROL, x, 6'(n));
         send(rotshift_pkg::OP_ROR, y, 6'(n));
      end
      finish_test("rotates");
   endtask

   task automatic shifts_all_amounts();
      logic [63:0] x;
      for (int n = 0; n < 64; n++)
      begin
         x = rand_bits(64);
         send(rotshift_pkg::OP_SLL, x, 6'(n));
         send(rotshift_pkg::OP_SRL, x, 6'(n));
      end
      finish_test("logical shifts");
   endtask

   task automatic sign_fill();
      logic [63:0] x;
      for (int n = 0; n < 64; n++)
      begin
         x = rand_bits(64);
         send(rotshift_pkg::OP_SRA, {1'b1, x[62:0]}, 6'(n));
         send(rotshift_pkg::OP_SRA, {1'b0, x[62:0]}, 6'(n));
      end
      finish_test("arithmetic shift");
   endtask

   // codes 5 to 7 alternate with legal requests.
   task automatic illegal_codes();
      logic [63:0] x;
      for (int i = 0; i < 16; i++)
      begin
         x = rand_bits(64);
         send(3'(5 + i % 3), x, x[5:0]);
         send(3'(i % 5), ~x, x[11:6]);
      end
      finish_test("illegal opcodes");
   endtask

   task automatic random_stalls();
      logic [63:0] x;
      logic [63:0] r;
      @(posedge clk);
      ready_pattern = rand_bits(64);
      stall_mode    = 1'b1;
      for (int i = 0; i < 200; i++)
      begin
         x = rand_bits(64);
         r = rand_bits(11);
         send(r[10:8], x, r[7:2]);
         idle_cycles(int'(r[1:0]));
      end
      finish_test("back-pressure");
      @(posedge clk);
      stall_mode = 1'b0;
   endtask

   // one lone request, then a back-to-back burst.
   task automatic latency_burst();
      logic [63:0] x;
      x = rand_bits(64);
      send(rotshift_pkg::OP_ROL, x, x[5:0]);
      idle_cycles(8);
      for (int i = 0; i < 32; i++)
      begin
         x = rand_bits(64);
         send(rotshift_pkg::OP_SLL, x, x[5:0]);
      end
      finish_test("latency");
   endtask

   // rsp_ready changes only on the falling edge.
   initial
   begin
      logic [5:0] pos;
      pos       = '0;
      rsp_ready = 1'b1;
      forever
      begin
         @(negedge clk);
         rsp_ready = stall_mode ? ready_pattern[pos] : 1'b1;
         pos       = pos + 6'd1;
      end
   end

   initial
   begin
      repeat (N_REQ * 20 + 200) @(posedge clk);
      $display("timeout after %0d cycles, the tests did not complete", N_REQ * 20 + 200);
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      lfsr_state    = 32'h7470_3b9b;
      rst           = 1'b1;
      req_valid     = 1'b0;
      req           = '0;
      stall_mode    = 1'b0;
      ready_pattern = '1;
      tests         = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      rotates_all_amounts();
      shifts_all_amounts();
      sign_fill();
      illegal_codes();
      random_stalls();
      latency_burst();
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: rotshift.f
hdl/rotshift_pkg.sv
hdl/shift_decode.sv
hdl/barrel_rotator.sv
hdl/shift_result.sv
hdl/rotshift_top.sv
bench/rotshift_checker.sv
bench/rotshift_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module rotshift_tb \
   -f rotshift.f -o rotshift_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rotshift_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0
